// File: common/riscv_pkg.sv
`default_nettype none

package riscv_pkg;

  ////////////////////////////////////////////////////////////
  // widths
  ////////////////////////////////////////////////////////////
  localparam int XLEN       = 64;
  localparam int INST_W     = 32;
  localparam int REG_ADDR_W = 5;

  localparam logic [XLEN-1:0] RESET_PC = '0;

  ////////////////////////////////////////////////////////////
  // major opcodes
  ////////////////////////////////////////////////////////////
  localparam logic [6:0] OPC_OP        = 7'b0110011;
  localparam logic [6:0] OPC_OP_IMM    = 7'b0010011;
  localparam logic [6:0] OPC_OP_32     = 7'b0111011;
  localparam logic [6:0] OPC_OP_IMM_32 = 7'b0011011;
  localparam logic [6:0] OPC_LUI       = 7'b0110111;
  localparam logic [6:0] OPC_AUIPC     = 7'b0010111;

  ////////////////////////////////////////////////////////////
  // control and forwarding types
  ////////////////////////////////////////////////////////////
  typedef enum logic [3:0] {
    ALU_ADD,
    ALU_SUB,
    ALU_SLL,
    ALU_SLT,
    ALU_SLTU,
    ALU_XOR,
    ALU_SRL,
    ALU_SRA,
    ALU_OR,
    ALU_AND,
    ALU_PASS_B   // lui
  } alu_op_t;

  typedef enum logic [1:0] {
    FWD_REG = 2'b00,
    FWD_MEM = 2'b01,
    FWD_WB  = 2'b10
  } fwd_sel_t;

  typedef struct packed {
    logic    regw;   // write rd
    logic    asel;   // operand a is pc
    logic    bsel;   // operand b is imm
    logic    word;   // 32-bit op, sign-extended
    alu_op_t aluop;
  } ctrl_t;

  ////////////////////////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////////////////////////
  typedef struct packed {
    logic              valid;
    logic [XLEN-1:0]   pc;
    logic [INST_W-1:0] inst;
  } fd_t;

  typedef struct packed {
    logic                  valid;
    logic [XLEN-1:0]       pc;
    logic [REG_ADDR_W-1:0] rs1addr;
    logic [REG_ADDR_W-1:0] rs2addr;
    logic [XLEN-1:0]       rs1data;
    logic [XLEN-1:0]       rs2data;
    logic [REG_ADDR_W-1:0] rdaddr;
    logic [XLEN-1:0]       imm;
    ctrl_t                 ctrl;
  } de_t;

  typedef struct packed {
    logic                  valid;
    logic                  regw;
    logic [REG_ADDR_W-1:0] rdaddr;
    logic [XLEN-1:0]       result;
  } em_t;

  typedef em_t mw_t;   // memory stage only carries the result on

endpackage

`default_nettype wire

// File: decode/riscv_control_unit.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_control_unit
  import riscv_pkg::*;
(
  input  logic [INST_W-1:0] i_inst,
  output ctrl_t             o_ctrl
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic       funct7_5;

  assign opcode   = i_inst[6:0];
  assign funct3   = i_inst[14:12];
  assign funct7_5 = i_inst[30];

  // sub exists only in register form, bit 30 of an addi is imm
  function automatic alu_op_t alu_from_funct(input logic [2:0] f3,
                                             input logic       f7_5,
                                             input logic       is_reg);
    case (f3)
      3'b000:  return (is_reg && f7_5) ? ALU_SUB : ALU_ADD;
      3'b001:  return ALU_SLL;
      3'b010:  return ALU_SLT;
      3'b011:  return ALU_SLTU;
      3'b100:  return ALU_XOR;
      3'b101:  return f7_5 ? ALU_SRA : ALU_SRL;
      3'b110:  return ALU_OR;
      default: return ALU_AND;
    endcase
  endfunction

  always_comb begin
    o_ctrl = '0;   // unsupported opcode, no write
    case (opcode)
      OPC_OP: begin
        o_ctrl.regw  = 1'b1;
        o_ctrl.aluop = alu_from_funct(funct3, funct7_5, 1'b1);
      end
      OPC_OP_IMM: begin
        o_ctrl.regw  = 1'b1;
        o_ctrl.bsel  = 1'b1;
        o_ctrl.aluop = alu_from_funct(funct3, funct7_5, 1'b0);
      end
      OPC_OP_32: begin
        o_ctrl.regw  = 1'b1;
        o_ctrl.word  = 1'b1;
        o_ctrl.aluop = alu_from_funct(funct3, funct7_5, 1'b1);
      end
      OPC_OP_IMM_32: begin
        o_ctrl.regw  = 1'b1;
        o_ctrl.bsel  = 1'b1;
        o_ctrl.word  = 1'b1;
        o_ctrl.aluop = alu_from_funct(funct3, funct7_5, 1'b0);
      end
      OPC_LUI: begin
        o_ctrl.regw  = 1'b1;
        o_ctrl.bsel  = 1'b1;
        o_ctrl.aluop = ALU_PASS_B;
      end
      OPC_AUIPC: begin
        o_ctrl.regw  = 1'b1;
        o_ctrl.asel  = 1'b1;   // pc + u-imm
        o_ctrl.bsel  = 1'b1;
        o_ctrl.aluop = ALU_ADD;
      end
      default: begin
        o_ctrl.regw = 1'b0;
      end
    endcase
  end

endmodule

`default_nettype wire

// File: decode/riscv_dstage.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_dstage
  import riscv_pkg::*;
(
  input  logic i_clk,
  input  fd_t  i_fd,
  input  mw_t  i_wb,
  output de_t  o_de
);

  ctrl_t                 ctrl;
  logic [6:0]            opcode;
  logic [REG_ADDR_W-1:0] rs1addr, rs2addr, rdaddr;
  logic [XLEN-1:0]       rs1data, rs2data, imm;

  assign opcode  = i_fd.inst[6:0];
  assign rdaddr  = i_fd.inst[11:7];
  assign rs1addr = i_fd.inst[19:15];
  assign rs2addr = i_fd.inst[24:20];

  // u-type for lui/auipc, i-type otherwise
  always_comb begin
    if (opcode == OPC_LUI || opcode == OPC_AUIPC) begin
      imm = {{(XLEN-32){i_fd.inst[31]}}, i_fd.inst[31:12], 12'b0};
    end else begin
      imm = {{(XLEN-12){i_fd.inst[31]}}, i_fd.inst[31:20]};
    end
  end

  riscv_control_unit u_control_unit (
    .i_inst (i_fd.inst),
    .o_ctrl (ctrl)
  );

  riscv_regfile u_regfile (
    .i_clk    (i_clk),
    .i_we     (i_wb.regw),
    .i_waddr  (i_wb.rdaddr),
    .i_raddr1 (rs1addr),
    .i_raddr2 (rs2addr),
    .i_wdata  (i_wb.result),
    .o_rdata1 (rs1data),
    .o_rdata2 (rs2data)
  );

  always_comb begin
    o_de.valid     = i_fd.valid;
    o_de.pc        = i_fd.pc;
    o_de.rs1addr   = rs1addr;
    o_de.rs2addr   = rs2addr;
    o_de.rs1data   = rs1data;
    o_de.rs2data   = rs2data;
    o_de.rdaddr    = rdaddr;
    o_de.imm       = imm;
    o_de.ctrl      = ctrl;
    o_de.ctrl.regw = ctrl.regw && i_fd.valid && (rdaddr != '0);   // bubbles and x0 never write
  end

endmodule

`default_nettype wire

// File: decode/riscv_regfile.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_regfile
  import riscv_pkg::*;
(
  input  logic                  i_clk,
  input  logic                  i_we,
  input  logic [REG_ADDR_W-1:0] i_waddr,
  input  logic [REG_ADDR_W-1:0] i_raddr1,
  input  logic [REG_ADDR_W-1:0] i_raddr2,
  input  logic [XLEN-1:0]       i_wdata,
  output logic [XLEN-1:0]       o_rdata1,
  output logic [XLEN-1:0]       o_rdata2
);

  logic [XLEN-1:0] regs [0:31];

  // falling edge write, decode sees it before the next rising edge
  always_ff @(negedge i_clk) begin
    if (i_we && (i_waddr != '0)) begin
      regs[i_waddr] <= i_wdata;
    end
  end

  assign o_rdata1 = (i_raddr1 == '0) ? '0 : regs[i_raddr1];   // x0 hardwired
  assign o_rdata2 = (i_raddr2 == '0) ? '0 : regs[i_raddr2];

  // writeback never targets x0, decode drops regw for rd 0
  a_no_x0_write : assert property (
    @(posedge i_clk) i_we |-> (i_waddr != '0)
  );

endmodule

`default_nettype wire

// File: execute/riscv_alu.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_alu
  import riscv_pkg::*;
(
  input  logic [XLEN-1:0] i_a,
  input  logic [XLEN-1:0] i_b,
  input  alu_op_t         i_op,
  input  logic            i_word,
  output logic [XLEN-1:0] o_result
);

  logic [XLEN-1:0] res64;
  logic [31:0]     res32;
  logic [5:0]      shamt;

  assign shamt = i_word ? {1'b0, i_b[4:0]} : i_b[5:0];   // 5-bit in word mode

  always_comb begin
    case (i_op)
      ALU_ADD:    res64 = i_a + i_b;
      ALU_SUB:    res64 = i_a - i_b;
      ALU_SLL:    res64 = i_a << shamt;
      ALU_SLT:    res64 = {{(XLEN-1){1'b0}}, $signed(i_a) < $signed(i_b)};
      ALU_SLTU:   res64 = {{(XLEN-1){1'b0}}, i_a < i_b};
      ALU_XOR:    res64 = i_a ^ i_b;
      ALU_SRL:    res64 = i_a >> shamt;
      ALU_SRA:    res64 = $signed(i_a) >>> shamt;
      ALU_OR:     res64 = i_a | i_b;
      ALU_AND:    res64 = i_a & i_b;
      ALU_PASS_B: res64 = i_b;
      default:    res64 = '0;
    endcase
  end

  // right shifts must only see the low word
  always_comb begin
    case (i_op)
      ALU_SRL: res32 = i_a[31:0] >> shamt[4:0];
      ALU_SRA: res32 = $signed(i_a[31:0]) >>> shamt[4:0];
      default: res32 = res64[31:0];   // add/sub/sll low half already right
    endcase
  end

  assign o_result = i_word ? {{(XLEN-32){res32[31]}}, res32} : res64;

endmodule

`default_nettype wire

// File: execute/riscv_estage.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_estage
  import riscv_pkg::*;
(
  input  de_t             i_de,
  input  fwd_sel_t        i_fwda,
  input  fwd_sel_t        i_fwdb,
  input  logic [XLEN-1:0] i_fwd_m,
  input  logic [XLEN-1:0] i_fwd_w,
  output em_t             o_em
);

  logic [XLEN-1:0] rs1_val, rs2_val;
  logic [XLEN-1:0] opa, opb, result;

  function automatic logic [XLEN-1:0] fwd_mux(input fwd_sel_t        sel,
                                              input logic [XLEN-1:0] reg_val);
    case (sel)
      FWD_MEM: return i_fwd_m;
      FWD_WB:  return i_fwd_w;
      default: return reg_val;
    endcase
  endfunction

  assign rs1_val = fwd_mux(i_fwda, i_de.rs1data);
  assign rs2_val = fwd_mux(i_fwdb, i_de.rs2data);

  assign opa = i_de.ctrl.asel ? i_de.pc  : rs1_val;   // auipc
  assign opb = i_de.ctrl.bsel ? i_de.imm : rs2_val;

  riscv_alu u_alu (
    .i_a      (opa),
    .i_b      (opb),
    .i_op     (i_de.ctrl.aluop),
    .i_word   (i_de.ctrl.word),
    .o_result (result)
  );

  always_comb begin
    o_em.valid  = i_de.valid;
    o_em.regw   = i_de.ctrl.regw;
    o_em.rdaddr = i_de.rdaddr;
    o_em.result = result;
  end

endmodule

`default_nettype wire

// File: project.f
+incdir+sim
common/riscv_pkg.sv
source/riscv_pipe_reg.sv
source/riscv_fetch.sv
source/riscv_hazard_unit.sv
decode/riscv_control_unit.sv
decode/riscv_regfile.sv
decode/riscv_dstage.sv
execute/riscv_alu.sv
execute/riscv_estage.sv
source/riscv_datapath.sv
sim/tb_riscv_datapath.sv

// File: run_sim.sh
#!/bin/sh
# build with Verilator, run, and decide pass or fail from the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --top-module tb_riscv_datapath -f project.f \
  && ./obj_dir/Vtb_riscv_datapath > sim.log 2>&1
cat sim.log 2>/dev/null
grep -q "^Test passed$" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }

// File: sim/riscv_ref_model.svh
`ifndef RISCV_REF_MODEL_SVH
`define RISCV_REF_MODEL_SVH

////////////////////////////////////////////////////////////
// in-order rv64i model for the kept opcodes
////////////////////////////////////////////////////////////

function automatic logic [XLEN-1:0] sext_word(input logic [31:0] w);
  return {{(XLEN-32){w[31]}}, w};
endfunction

// true when the instruction retires with a register write
function automatic logic writes_rd(input logic [INST_W-1:0] iw);
  logic [6:0] opc;
  opc = iw[6:0];
  return (iw[11:7] != 5'd0) &&
         (opc == OPC_OP || opc == OPC_OP_IMM || opc == OPC_OP_32 ||
          opc == OPC_OP_IMM_32 || opc == OPC_LUI || opc == OPC_AUIPC);
endfunction

function automatic logic [XLEN-1:0] ref_result(input logic [INST_W-1:0] iw,
                                               input logic [XLEN-1:0]   pc_i,
                                               input logic [XLEN-1:0]   a,
                                               input logic [XLEN-1:0]   b);
  logic [XLEN-1:0] imm_i;
  logic [XLEN-1:0] imm_u;
  logic [XLEN-1:0] op2;
  logic [31:0]     aw;
  logic            alt;
  logic [XLEN-1:0] y;
  imm_i = {{(XLEN-12){iw[31]}}, iw[31:20]};
  imm_u = {{(XLEN-32){iw[31]}}, iw[31:12], 12'h000};
  op2   = iw[5] ? b : imm_i;   // bit 5 splits register and immediate forms
  aw    = a[31:0];
  alt   = iw[30];
  y     = '0;
  case (iw[6:0])
    OPC_LUI:   y = imm_u;
    OPC_AUIPC: y = pc_i + imm_u;   // pc of this instruction
    OPC_OP, OPC_OP_IMM: begin
      case (iw[14:12])
        3'd0:    y = (iw[5] && alt) ? a - op2 : a + op2;
        3'd1:    y = a << op2[5:0];
        3'd2:    y = ($signed(a) < $signed(op2)) ? XLEN'(1) : XLEN'(0);
        3'd3:    y = (a < op2) ? XLEN'(1) : XLEN'(0);
        3'd4:    y = a ^ op2;
        3'd5: begin
          if (alt) y = $signed(a) >>> op2[5:0];   // sign fills from bit 63
          else     y = a >> op2[5:0];
        end
        3'd6:    y = a | op2;
        default: y = a & op2;
      endcase
    end
    OPC_OP_32, OPC_OP_IMM_32: begin
      case (iw[14:12])
        3'd0:    y = sext_word((iw[5] && alt) ? aw - op2[31:0] : aw + op2[31:0]);
        3'd1:    y = sext_word(aw << op2[4:0]);
        default: y = alt ? sext_word($signed(aw) >>> op2[4:0]) : sext_word(aw >> op2[4:0]);
      endcase
    end
    default: y = '0;   // no write
  endcase
  return y;
endfunction

task automatic run_ref_model();
  logic [XLEN-1:0] regs [0:31];
  logic [XLEN-1:0] val;
  for (int r = 0; r < 32; r++) begin
    regs[r] = '0;
  end
  for (int i = 0; i < PROG_LEN; i++) begin
    val = ref_result(prog[i], RESET_PC + XLEN'(i) * XLEN'(4),
                     regs[prog[i][19:15]], regs[prog[i][24:20]]);
    if (writes_rd(prog[i])) begin
      regs[prog[i][11:7]] = val;
      exp_rd.push_back(prog[i][11:7]);
      exp_val.push_back(val);
    end
  end
endtask

`endif

// File: sim/tb_riscv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module tb_riscv_datapath
  import riscv_pkg::*;
();

  localparam int PROG_LEN    = 400;
  localparam int RUN_TIMEOUT = 8 * PROG_LEN;   // cycles
  localparam int DRAIN_LIMIT = 64;

  logic                  clk;
  logic                  rst_n;
  logic [INST_W-1:0]     inst;
  logic                  inst_valid;
  logic [XLEN-1:0]       pc;
  logic                  regw_wb;
  logic [REG_ADDR_W-1:0] rdaddr_wb;
  logic [XLEN-1:0]       rddata_wb;

  logic [INST_W-1:0]     prog [0:PROG_LEN-1];
  logic [REG_ADDR_W-1:0] exp_rd [$];
  logic [XLEN-1:0]       exp_val [$];
  int                    exp_total = 0;
  int                    n_retired = 0;

  riscv_datapath u_dut (
    .i_riscv_datapath_clk (clk),
    .i_rst_n              (rst_n),
    .i_inst               (inst),
    .i_inst_valid         (inst_valid),
    .o_pc                 (pc),
    .o_regw_wb            (regw_wb),
    .o_rdaddr_wb          (rdaddr_wb),
    .o_rddata_wb          (rddata_wb)
  );

  always #10 clk = ~clk;

  `include "riscv_ref_model.svh"

  task automatic abort_run();
    $display("Test failed");
    $fatal(1);
  endtask

  task automatic check_value(input string           what,
                             input logic [XLEN-1:0] got,
                             input logic [XLEN-1:0] exp);
    if (got !== exp) begin
      $display("Fail at time %0t: %s, got %h, expected %h", $time, what, got, exp);
      abort_run();
    end
  endtask

  ////////////////////////////////////////////////////////////
  // random program, registers x0..x7 only
  ////////////////////////////////////////////////////////////
  function automatic logic [INST_W-1:0] gen_inst();
    logic [4:0]  rd, rs1, rs2;
    logic [2:0]  f3;
    logic [11:0] imm;
    logic        alt;
    int unsigned kind;
    kind = $urandom % 16;
    rd   = 5'($urandom % 8);   // small set keeps dependencies close
    rs1  = 5'($urandom % 8);
    rs2  = 5'($urandom % 8);
    f3   = 3'($urandom);
    alt  = 1'($urandom);
    imm  = 12'($urandom);
    if (kind < 4) begin
      return {((f3 == 3'd0 || f3 == 3'd5) && alt) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, OPC_OP};
    end else if (kind < 8) begin
      if (f3 == 3'd1) imm = {6'b0, imm[5:0]};
      if (f3 == 3'd5) imm = {alt ? 6'b010000 : 6'b0, imm[5:0]};
      return {imm, rs1, f3, rd, OPC_OP_IMM};
    end else if (kind < 12) begin
      f3 = f3[0] ? 3'd0 : (f3[1] ? 3'd1 : 3'd5);   // legal word ops only
      if (kind < 10) begin
        return {(f3 != 3'd1 && alt) ? 7'b0100000 : 7'b0, rs2, rs1, f3, rd, OPC_OP_32};
      end
      if (f3 != 3'd0) imm = {(f3 == 3'd5 && alt) ? 7'b0100000 : 7'b0, imm[4:0]};
      return {imm, rs1, f3, rd, OPC_OP_IMM_32};
    end else if (kind == 12) begin
      return {20'($urandom), rd, OPC_LUI};
    end else if (kind == 13) begin
      return {20'($urandom), rd, OPC_AUIPC};
    end else if (kind == 14) begin
      case ($urandom % 4)   // load, store, branch, system
        0:       return {25'($urandom), 7'b0000011};
        1:       return {25'($urandom), 7'b0100011};
        2:       return {25'($urandom), 7'b1100011};
        default: return {25'($urandom), 7'b1110011};
      endcase
    end
    return {imm, rd, 3'b000, rd, OPC_OP_IMM};   // addi on itself
  endfunction

  // retirement port is stable between rising edges
  always @(negedge clk) begin
    if (rst_n && regw_wb) begin
      if (exp_rd.size() == 0) begin
        $display("DUT wrote x%0d but the model expects no more writes", rdaddr_wb);
        abort_run();
      end else begin
        check_value("rd address", XLEN'(rdaddr_wb), XLEN'(exp_rd.pop_front()));
        check_value($sformatf("x%0d data", rdaddr_wb), rddata_wb, exp_val.pop_front());
        n_retired++;
      end
    end
  end

  initial begin
    int unsigned     seed_ret;
    int              idx;
    int              cycles;
    logic [XLEN-1:0] exp_pc;
    logic            last_valid;
    seed_ret   = $urandom(32'h8f40);
    clk        = 1'b0;
    rst_n      = 1'b0;
    inst       = '0;
    inst_valid = 1'b0;
    // first seven define x1..x7
    for (int i = 0; i < PROG_LEN; i++) begin
      if (i < 7) prog[i] = {12'($urandom), 5'd0, 3'b000, 5'(i + 1), OPC_OP_IMM};
      else       prog[i] = gen_inst();
    end
    run_ref_model();
    exp_total = exp_rd.size();

    repeat (16) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    check_value("pc after reset", pc, RESET_PC);
    check_value("regw after reset", XLEN'(regw_wb), '0);

    ////////////////////////////////////////////////////////////
    // fetch loop, pc checked every cycle
    ////////////////////////////////////////////////////////////
    exp_pc     = RESET_PC;
    last_valid = 1'b0;
    cycles     = 0;
    idx        = 0;
    while (idx < PROG_LEN && cycles < RUN_TIMEOUT) begin
      @(negedge clk);
      cycles++;
      if (last_valid) exp_pc = exp_pc + XLEN'(4);   // bubble holds the pc
      check_value("pc", pc, exp_pc);
      idx = int'((pc - RESET_PC) >> 2);
      if (idx < PROG_LEN) begin
        inst       = prog[idx];
        inst_valid = ($urandom % 4) != 0;
      end else begin
        inst       = '0;
        inst_valid = 1'b0;
      end
      last_valid = inst_valid;
    end

    if (idx < PROG_LEN) begin
      $display("timeout: program not fetched within %0d cycles", RUN_TIMEOUT);
      abort_run();
    end else begin
      cycles = 0;
      while (n_retired < exp_total && cycles < DRAIN_LIMIT) begin
        @(posedge clk);
        cycles++;
      end
      if (n_retired < exp_total) begin
        $display("timeout: only %0d of %0d writes retired", n_retired, exp_total);
        abort_run();
      end else begin
        repeat (8) @(posedge clk);   // late extra writes hit the monitor
        $display("Test passed");
        $finish;
      end
    end
  end

endmodule

`default_nettype wire

// File: source/riscv_datapath.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_datapath
  import riscv_pkg::*;
(
  input  logic                  i_riscv_datapath_clk,
  input  logic                  i_rst_n,
  input  logic [INST_W-1:0]     i_inst,
  input  logic                  i_inst_valid,
  output logic [XLEN-1:0]       o_pc,
  output logic                  o_regw_wb,
  output logic [REG_ADDR_W-1:0] o_rdaddr_wb,
  output logic [XLEN-1:0]       o_rddata_wb
);

  ////////////////////////////////////////////////////////////
  // stage payloads
  ////////////////////////////////////////////////////////////
  fd_t      fd_f, fd_d;
  de_t      de_d, de_e;
  em_t      em_e, em_m;
  mw_t      mw_w;
  fwd_sel_t fwda, fwdb;

  assign o_regw_wb   = mw_w.regw;     // retirement port
  assign o_rdaddr_wb = mw_w.rdaddr;
  assign o_rddata_wb = mw_w.result;

  ////////////////////////////////////////////////////////////
  // fetch and decode
  ////////////////////////////////////////////////////////////
  riscv_fetch u_fetch (
    .i_clk        (i_riscv_datapath_clk),
    .i_rst_n      (i_rst_n),
    .i_inst_valid (i_inst_valid),
    .i_inst       (i_inst),
    .o_pc         (o_pc),
    .o_fd         (fd_f)
  );

  riscv_pipe_reg #(.T(fd_t)) u_fd_reg (
    .i_clk   (i_riscv_datapath_clk),
    .i_rst_n (i_rst_n),
    .i_d     (fd_f),
    .o_q     (fd_d)
  );

  riscv_dstage u_dstage (
    .i_clk (i_riscv_datapath_clk),
    .i_fd  (fd_d),
    .i_wb  (mw_w),     // regfile write port
    .o_de  (de_d)
  );

  riscv_pipe_reg #(.T(de_t)) u_de_reg (
    .i_clk   (i_riscv_datapath_clk),
    .i_rst_n (i_rst_n),
    .i_d     (de_d),
    .o_q     (de_e)
  );

  ////////////////////////////////////////////////////////////
  // execute, memory, writeback
  ////////////////////////////////////////////////////////////
  riscv_hazard_unit u_hazard_unit (
    .i_de   (de_e),
    .i_em   (em_m),
    .i_mw   (mw_w),
    .o_fwda (fwda),
    .o_fwdb (fwdb)
  );

  riscv_estage u_estage (
    .i_de    (de_e),
    .i_fwda  (fwda),
    .i_fwdb  (fwdb),
    .i_fwd_m (em_m.result),
    .i_fwd_w (mw_w.result),
    .o_em    (em_e)
  );

  riscv_pipe_reg #(.T(em_t)) u_em_reg (
    .i_clk   (i_riscv_datapath_clk),
    .i_rst_n (i_rst_n),
    .i_d     (em_e),
    .o_q     (em_m)
  );

  riscv_pipe_reg #(.T(mw_t)) u_mw_reg (
    .i_clk   (i_riscv_datapath_clk),
    .i_rst_n (i_rst_n),
    .i_d     (em_m),   // no loads, result passes through
    .o_q     (mw_w)
  );

endmodule

`default_nettype wire

// File: source/riscv_fetch.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_fetch
  import riscv_pkg::*;
(
  input  logic              i_clk,
  input  logic              i_rst_n,
  input  logic              i_inst_valid,
  input  logic [INST_W-1:0] i_inst,
  output logic [XLEN-1:0]   o_pc,
  output fd_t               o_fd
);

  logic [XLEN-1:0] pc_q;

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      pc_q <= RESET_PC;
    end else if (i_inst_valid) begin
      pc_q <= pc_q + XLEN'(4);   // no branches, always sequential
    end
  end

  assign o_pc = pc_q;

  always_comb begin
    o_fd.valid = i_inst_valid;   // low makes a bubble
    o_fd.pc    = pc_q;
    o_fd.inst  = i_inst;
  end

  a_pc_hold : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    !i_inst_valid |=> (o_pc == $past(o_pc))
  );

endmodule

`default_nettype wire

// File: source/riscv_hazard_unit.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_hazard_unit
  import riscv_pkg::*;
(
  input  de_t      i_de,
  input  em_t      i_em,
  input  mw_t      i_mw,
  output fwd_sel_t o_fwda,
  output fwd_sel_t o_fwdb
);

  // regw is already clear for rd 0, decode gates it
  function automatic fwd_sel_t pick_fwd(input logic [REG_ADDR_W-1:0] rs);
    if (i_em.regw && (i_em.rdaddr == rs)) begin
      return FWD_MEM;   // youngest result wins
    end else if (i_mw.regw && (i_mw.rdaddr == rs)) begin
      return FWD_WB;
    end
    return FWD_REG;
  endfunction

  assign o_fwda = pick_fwd(i_de.rs1addr);
  assign o_fwdb = pick_fwd(i_de.rs2addr);

  // x0 must always read as zero from the register file
  always_comb begin
    if (i_de.rs1addr == '0) assert (o_fwda == FWD_REG);
    if (i_de.rs2addr == '0) assert (o_fwdb == FWD_REG);
  end

endmodule

`default_nettype wire

// File: source/riscv_pipe_reg.sv
`timescale 1ns/1ps
`default_nettype none

module riscv_pipe_reg
  import riscv_pkg::*;
#(
  parameter type T = em_t
) (
  input  logic i_clk,
  input  logic i_rst_n,
  input  T     i_d,
  output T     o_q
);

  always_ff @(posedge i_clk or negedge i_rst_n) begin
    if (!i_rst_n) begin
      o_q <= '0;   // empty payload, valid clear
    end else begin
      o_q <= i_d;
    end
  end

  // an empty slot only fills from a valid input
  a_valid_from_input : assert property (
    @(posedge i_clk) disable iff (!i_rst_n)
    (!o_q.valid && !i_d.valid) |=> !o_q.valid
  );

endmodule

`default_nettype wire
